// ==== design/tau_defs.svh ====
`ifndef TAU_DEFS_SVH
`define TAU_DEFS_SVH

// ======================================
// Data path sizing
// ======================================

// Width of every offset, pitch and flat address
`define TAU_WORK_BW 16

// Entries in the configuration table
`define TAU_N_CFG 4

// Lanes in a block or thread offset vector
`define TAU_VDIM 2

// Dimensions of a memory offset
`define TAU_DIM 2

// ======================================
// Stride fields
// ======================================

// Multiplier applied to a lane offset
`define TAU_FRAC_BW 3

// Left shift applied after the multiply
`define TAU_SHAMT_BW 3

// Id width, wide enough to hold TAU_N_CFG as a range end
`define TAU_CFG_ID_BW 3

`endif

// ==== design/tau_pkg.sv ====
`include "tau_defs.svh"

package tau_pkg;

	// Scalar words
	typedef logic [`TAU_WORK_BW-1:0] work_t;
	typedef logic [`TAU_CFG_ID_BW-1:0] cfg_id_t;
	typedef logic [$clog2(`TAU_DIM)-1:0] shuf_t;

	// Offset vectors, lane 0 in the low bits
	typedef work_t [`TAU_VDIM-1:0] lane_vec_t;
	typedef work_t [`TAU_DIM-1:0] dim_vec_t;

	// One lane field, shuffle target in the top bit
	typedef struct packed {
		shuf_t                    shuf;
		logic [`TAU_FRAC_BW-1:0]  frac;
		logic [`TAU_SHAMT_BW-1:0] shamt;
	} lane_stride_t;

	typedef lane_stride_t [`TAU_VDIM-1:0] stride_vec_t;

	// One access configuration
	typedef struct packed {
		dim_vec_t    base;
		work_t       pitch;
		stride_vec_t bstride;
		stride_vec_t astride;
	} cfg_entry_t;

	typedef cfg_entry_t [`TAU_N_CFG-1:0] cfg_tab_t;

	// Request, range is beg up to end_id exclusive
	typedef struct packed {
		lane_vec_t bofs;
		lane_vec_t aofs;
		cfg_id_t   beg;
		cfg_id_t   end_id;
	} tau_req_t;

	typedef struct packed {
		dim_vec_t mofs;
		cfg_id_t  id;
	} tau_mofs_t;

	typedef struct packed {
		work_t   addr;
		cfg_id_t id;
	} tau_addr_t;

	typedef enum logic [1:0] {
		HEAD_IDLE,
		HEAD_INIT,
		HEAD_EMIT
	} head_state_e;

	// Word index inside one table entry
	typedef enum logic [1:0] {
		CFG_WORD_BASE,
		CFG_WORD_PITCH,
		CFG_WORD_BSTRIDE,
		CFG_WORD_ASTRIDE
	} cfg_word_e;

endpackage

// ==== design/tau_cfg_regs.sv ====
`include "tau_defs.svh"

module tau_cfg_regs
	import tau_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_wb_cyc,
	input  logic        i_wb_stb,
	input  logic        i_wb_we,
	input  logic [3:0]  i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic        o_wb_ack,
	output logic [31:0] o_wb_dat,
	output cfg_tab_t    o_cfg_tab
);

	// ======================================
	// Address decode
	// ======================================
	localparam int ENT_BW = $clog2(`TAU_N_CFG);

	logic              wb_req;
	logic              wb_hit;
	logic [ENT_BW-1:0] ent_idx;
	cfg_word_e         word_idx;
	cfg_entry_t        sel_ent;
	logic [31:0]       rd_word;
	logic              ack_r;
	logic [31:0]       rd_dat_r;
	cfg_tab_t          tab_r;

	// Entry in the upper bits, word in the lower two
	assign ent_idx  = i_wb_adr[3:2];
	assign word_idx = cfg_word_e'(i_wb_adr[1:0]);
	assign sel_ent  = tab_r[ent_idx];

	assign wb_req = i_wb_cyc && i_wb_stb;
	// First cycle of a strobe, the one that raises ack
	assign wb_hit = wb_req && !ack_r;

	// ======================================
	// Read packing
	// ======================================
	always_comb begin
		rd_word = '0;
		unique case (word_idx)
			// base[1] lands in the high half
			CFG_WORD_BASE:    rd_word[$bits(dim_vec_t)-1:0] = sel_ent.base;
			CFG_WORD_PITCH:   rd_word[`TAU_WORK_BW-1:0] = sel_ent.pitch;
			// Lane 0 field in bits 6:0
			CFG_WORD_BSTRIDE: rd_word[$bits(stride_vec_t)-1:0] = sel_ent.bstride;
			CFG_WORD_ASTRIDE: rd_word[$bits(stride_vec_t)-1:0] = sel_ent.astride;
		endcase
	end

	// ======================================
	// Table and acknowledge
	// ======================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			tab_r <= '0;
			ack_r <= 1'b0;
		end else begin
			// One cycle pulse per strobe
			ack_r <= wb_hit;
			if (wb_hit && i_wb_we) begin
				unique case (word_idx)
					CFG_WORD_BASE:
						tab_r[ent_idx].base <= i_wb_dat[$bits(dim_vec_t)-1:0];
					CFG_WORD_PITCH:
						tab_r[ent_idx].pitch <= i_wb_dat[`TAU_WORK_BW-1:0];
					CFG_WORD_BSTRIDE:
						tab_r[ent_idx].bstride <= i_wb_dat[$bits(stride_vec_t)-1:0];
					CFG_WORD_ASTRIDE:
						tab_r[ent_idx].astride <= i_wb_dat[$bits(stride_vec_t)-1:0];
				endcase
			end
		end
	end

	// Read data captured alongside ack
	always_ff @(posedge i_clk) begin
		if (wb_hit) begin
			rd_dat_r <= rd_word;
		end
	end

	assign o_wb_ack  = ack_r;
	assign o_wb_dat  = rd_dat_r;
	assign o_cfg_tab = tab_r;

	// Held strobe must see ack drop before the next one
	a_ack_pulse: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(o_wb_ack && wb_req) |=> !o_wb_ack
	);

endmodule

// ==== design/tau_chunk_head.sv ====
`include "tau_defs.svh"

module tau_chunk_head
	import tau_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_req_rdy,
	input  tau_req_t  i_req,
	input  cfg_tab_t  i_cfg_tab,
	input  logic      i_mofs_ack,
	output logic      o_req_ack,
	output logic      o_mofs_rdy,
	output tau_mofs_t o_mofs
);

	// ======================================
	// Internal
	// ======================================
	localparam int ENT_BW = $clog2(`TAU_N_CFG);

	head_state_e state_r;
	cfg_id_t     cur_id_r;
	cfg_id_t     cur_id_nxt;
	logic        is_last;
	logic        load;
	logic        mofs_rdy_r;
	tau_mofs_t   mofs_r;
	cfg_entry_t  cur_cfg;
	lane_vec_t   bterm;
	lane_vec_t   aterm;
	dim_vec_t    mofs_sum;

	// Configuration of the id being worked on
	assign cur_cfg = i_cfg_tab[cur_id_r[ENT_BW-1:0]];

	assign cur_id_nxt = cur_id_r + 1'b1;
	assign is_last    = cur_id_nxt == i_req.end_id;

	// Output slot free or draining this cycle
	assign load = (state_r == HEAD_EMIT) && (!mofs_rdy_r || i_mofs_ack);

	// Request consumed with its last result
	assign o_req_ack = load && is_last;

	// ======================================
	// Stride terms
	// ======================================
	// Multiply and shift, truncated to work width
	always_comb begin
		for (int i = 0; i < `TAU_VDIM; i++) begin
			bterm[i] = (i_req.bofs[i] * cur_cfg.bstride[i].frac) << cur_cfg.bstride[i].shamt;
			aterm[i] = (i_req.aofs[i] * cur_cfg.astride[i].frac) << cur_cfg.astride[i].shamt;
		end
	end

	// ======================================
	// Shuffle accumulate
	// ======================================
	// Each lane adds into the dimension its shuffle picks
	always_comb begin
		for (int d = 0; d < `TAU_DIM; d++) begin
			mofs_sum[d] = cur_cfg.base[d];
			for (int i = 0; i < `TAU_VDIM; i++) begin
				if (cur_cfg.bstride[i].shuf == shuf_t'(d)) begin
					mofs_sum[d] = mofs_sum[d] + bterm[i];
				end
				if (cur_cfg.astride[i].shuf == shuf_t'(d)) begin
					mofs_sum[d] = mofs_sum[d] + aterm[i];
				end
			end
		end
	end

	// ======================================
	// Control
	// ======================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state_r    <= HEAD_IDLE;
			cur_id_r   <= '0;
			mofs_rdy_r <= 1'b0;
		end else begin
			unique case (state_r)
				HEAD_IDLE: begin
					if (i_req_rdy) begin
						state_r  <= HEAD_INIT;
						cur_id_r <= i_req.beg;
					end
				end
				// Settle cycle before the first result
				HEAD_INIT: state_r <= HEAD_EMIT;
				HEAD_EMIT: begin
					if (load) begin
						cur_id_r <= cur_id_nxt;
						if (is_last) begin
							state_r <= HEAD_IDLE;
						end
					end
				end
				default: state_r <= HEAD_IDLE;
			endcase
			mofs_rdy_r <= load || (mofs_rdy_r && !i_mofs_ack);
		end
	end

	// Result register
	always_ff @(posedge i_clk) begin
		if (load) begin
			mofs_r.mofs <= mofs_sum;
			mofs_r.id   <= cur_id_r;
		end
	end

	assign o_mofs_rdy = mofs_rdy_r;
	assign o_mofs     = mofs_r;

	// Range must be non-empty and inside the table
	a_req_range: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(state_r == HEAD_IDLE && i_req_rdy) |->
			(i_req.beg < i_req.end_id) && (i_req.end_id <= `TAU_N_CFG)
	);

	// Stalled result holds until taken
	a_mofs_hold: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(o_mofs_rdy && !i_mofs_ack) |=> (o_mofs_rdy && $stable(o_mofs))
	);

endmodule

// ==== design/tau_linearize.sv ====
`include "tau_defs.svh"

module tau_linearize
	import tau_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_mofs_rdy,
	input  tau_mofs_t i_mofs,
	input  cfg_tab_t  i_cfg_tab,
	input  logic      i_addr_ack,
	output logic      o_mofs_ack,
	output logic      o_addr_rdy,
	output tau_addr_t o_addr
);

	// ======================================
	// Internal
	// ======================================
	localparam int ENT_BW = $clog2(`TAU_N_CFG);

	work_t     pitch;
	work_t     flat;
	logic      take;
	logic      addr_rdy_r;
	tau_addr_t addr_r;

	// Row pitch of the incoming id
	assign pitch = i_cfg_tab[i_mofs.id[ENT_BW-1:0]].pitch;

	// Row times pitch plus column, wraps at work width
	assign flat = i_mofs.mofs[0] + i_mofs.mofs[1] * pitch;

	// Free when empty or emptied in the same cycle
	assign o_mofs_ack = !addr_rdy_r || i_addr_ack;
	assign take       = i_mofs_rdy && o_mofs_ack;

	// ======================================
	// Pipeline register
	// ======================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			addr_rdy_r <= 1'b0;
		end else begin
			addr_rdy_r <= take || (addr_rdy_r && !i_addr_ack);
		end
	end

	always_ff @(posedge i_clk) begin
		if (take) begin
			addr_r.addr <= flat;
			addr_r.id   <= i_mofs.id;
		end
	end

	assign o_addr_rdy = addr_rdy_r;
	assign o_addr     = addr_r;

	// Back-pressure must not disturb the presented address
	a_addr_hold: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(o_addr_rdy && !i_addr_ack) |=> (o_addr_rdy && $stable(o_addr))
	);

endmodule

// ==== design/tau_top.sv ====
`include "tau_defs.svh"

module tau_top
	import tau_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_wb_cyc,
	input  logic        i_wb_stb,
	input  logic        i_wb_we,
	input  logic [3:0]  i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic        o_wb_ack,
	output logic [31:0] o_wb_dat,
	input  logic        i_req_rdy,
	input  tau_req_t    i_req,
	output logic        o_req_ack,
	output logic        o_addr_rdy,
	output tau_addr_t   o_addr,
	input  logic        i_addr_ack
);

	// Table shared by both stages
	cfg_tab_t  cfg_tab;

	// Chunk head to linearize
	logic      mofs_rdy;
	logic      mofs_ack;
	tau_mofs_t mofs;

	// ======================================
	// Configuration port
	// ======================================
	tau_cfg_regs u_cfg (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wb_cyc  (i_wb_cyc),
		.i_wb_stb  (i_wb_stb),
		.i_wb_we   (i_wb_we),
		.i_wb_adr  (i_wb_adr),
		.i_wb_dat  (i_wb_dat),
		.o_wb_ack  (o_wb_ack),
		.o_wb_dat  (o_wb_dat),
		.o_cfg_tab (cfg_tab)
	);

	// ======================================
	// Pipeline
	// ======================================
	tau_chunk_head u_head (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_req_rdy  (i_req_rdy),
		.i_req      (i_req),
		.i_cfg_tab  (cfg_tab),
		.i_mofs_ack (mofs_ack),
		.o_req_ack  (o_req_ack),
		.o_mofs_rdy (mofs_rdy),
		.o_mofs     (mofs)
	);

	tau_linearize u_lin (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_mofs_rdy (mofs_rdy),
		.i_mofs     (mofs),
		.i_cfg_tab  (cfg_tab),
		.i_addr_ack (i_addr_ack),
		.o_mofs_ack (mofs_ack),
		.o_addr_rdy (o_addr_rdy),
		.o_addr     (o_addr)
	);

endmodule

// ==== verification/tb_clkgen.sv ====
module tb_clkgen (
	output logic o_clk,
	output logic o_rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period, first rising edge at 4 ns
	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	// Ten rising edges in reset, released on a falling edge
	initial begin
		o_rst_n = 1'b0;
		repeat (10) @(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

// ==== verification/tb_top.sv ====
`include "tau_defs.svh"

module tb_top
	import tau_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_WORDS     = `TAU_N_CFG * 4;
	localparam int N_REQ       = 12;
	localparam int TIMEOUT_CYC = N_WORDS * 4 + N_REQ * (3 + `TAU_N_CFG) * 4 + 200;

	logic        clk;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_adr;
	logic [31:0] wb_dat;
	logic        wb_ack;
	logic [31:0] wb_rdat;
	logic        req_rdy;
	tau_req_t    req;
	logic        req_ack;
	logic        addr_rdy;
	tau_addr_t   addr_out;
	logic        addr_ack = 1'b1;

	// Model state
	logic [15:0] lfsr;
	logic [31:0] shadow [N_WORDS];
	logic [31:0] wr_words [N_WORDS];
	tau_req_t    reqs [N_REQ];
	logic        ack_pat [512];
	logic [8:0]  ack_idx = '0;
	tau_addr_t   exp_q [$];
	tau_addr_t   exp_head = '0;
	logic        exp_valid = 1'b0;
	logic        rand_ack;
	logic        lat_arm;
	logic        rd_chk;
	logic [31:0] rd_exp;
	logic        req_xfer_q = 1'b0;
	logic        addr_xfer_q = 1'b0;
	int          cyc = 0;

	tb_clkgen u_clk (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	tau_top dut (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_we    (wb_we),
		.i_wb_adr   (wb_adr),
		.i_wb_dat   (wb_dat),
		.o_wb_ack   (wb_ack),
		.o_wb_dat   (wb_rdat),
		.i_req_rdy  (req_rdy),
		.i_req      (req),
		.o_req_ack  (req_ack),
		.o_addr_rdy (addr_rdy),
		.o_addr     (addr_out),
		.i_addr_ack (addr_ack)
	);

	// ========================================
	// Helpers
	// ========================================
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		stop_with_error($sformatf("MISMATCH %s expected=0x%0h actual=0x%0h", name, exp, act));
	endtask

	// Galois LFSR, taps for a maximal 16-bit sequence
	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = next_lfsr(lfsr);
		end
		return v;
	endfunction

	// Bits each word keeps, 7 bits per stride lane
	function automatic logic [31:0] word_mask(input logic [3:0] adr);
		case (adr[1:0])
			2'd0:    return 32'hFFFF_FFFF;
			2'd1:    return 32'h0000_FFFF;
			default: return 32'h0000_3FFF;
		endcase
	endfunction

	// Stride, shuffle onto base, then fold rows with the pitch
	function automatic tau_addr_t model_addr(input tau_req_t r, input int id);
		dim_vec_t    m;
		logic [15:0] term;
		logic [6:0]  fld;
		tau_addr_t   res;
		int          w;
		w = id * 4;
		m[0] = shadow[w][15:0];
		m[1] = shadow[w][31:16];
		for (int i = 0; i < `TAU_VDIM; i++) begin
			// Field is shuffle bit, fraction, shift from the top
			fld = 7'(shadow[w + 2] >> (7 * i));
			term = (r.bofs[i] * fld[5:3]) << fld[2:0];
			m[fld[6]] = m[fld[6]] + term;
			fld = 7'(shadow[w + 3] >> (7 * i));
			term = (r.aofs[i] * fld[5:3]) << fld[2:0];
			m[fld[6]] = m[fld[6]] + term;
		end
		res.addr = m[0] + m[1] * shadow[w + 1][15:0];
		res.id   = cfg_id_t'(id);
		return res;
	endfunction

	task automatic build_stimulus();
		int beg_i;
		int span;
		for (int a = 0; a < N_WORDS; a++) begin
			wr_words[a] = rand_bits(32);
		end
		for (int n = 0; n < N_REQ; n++) begin
			beg_i = rand_bits(2);
			span  = rand_bits(2);
			reqs[n].beg    = cfg_id_t'(beg_i);
			reqs[n].end_id = cfg_id_t'(beg_i + 1 + span % (`TAU_N_CFG - beg_i));
			for (int i = 0; i < `TAU_VDIM; i++) begin
				reqs[n].bofs[i] = rand_bits(16);
				reqs[n].aofs[i] = rand_bits(16);
			end
		end
		// Sink takes about three cycles in four
		for (int k = 0; k < 512; k++) begin
			ack_pat[k] = rand_bits(2) != 0;
		end
	endtask

	// ========================================
	// Drivers
	// ========================================
	task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] dat);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = we;
		wb_adr = adr;
		wb_dat = dat;
		rd_chk = !we;
		rd_exp = shadow[adr];
		if (we) begin
			shadow[adr] = dat & word_mask(adr);
		end
		do begin
			@(negedge clk);
		end while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic send_req(input tau_req_t r, input logic arm);
		// Expected items queued on a rising edge
		@(posedge clk);
		for (int id = r.beg; id < r.end_id; id++) begin
			exp_q.push_back(model_addr(r, id));
		end
		@(negedge clk);
		req_rdy = 1'b1;
		req     = r;
		lat_arm = arm;
		@(negedge clk);
		lat_arm = 1'b0;
		// Held until the last id is consumed
		while (!req_xfer_q) begin
			@(negedge clk);
		end
		req_rdy = 1'b0;
	endtask

	// Address sink, pops on the falling edge after a transfer
	always @(negedge clk) begin
		if (addr_xfer_q && exp_q.size() != 0) begin
			void'(exp_q.pop_front());
		end
		exp_valid = exp_q.size() != 0;
		if (exp_valid) begin
			exp_head = exp_q[0];
		end
		if (rand_ack) begin
			addr_ack = ack_pat[ack_idx];
			ack_idx  = ack_idx + 1'b1;
		end else begin
			addr_ack = 1'b1;
		end
	end

	// Transfer flags and timeout
	always @(posedge clk) begin
		cyc         <= cyc + 1;
		req_xfer_q  <= req_rdy && req_ack;
		addr_xfer_q <= addr_rdy && addr_ack;
		if (cyc >= TIMEOUT_CYC) begin
			stop_with_error("Timeout, the run did not finish in time");
		end
	end

	// ========================================
	// Checks
	// ========================================
	a_reset_quiet: assert property (@(posedge clk)
		(cyc != 0 && (!rst_n || $rose(rst_n))) |-> (!addr_rdy && !req_ack && !wb_ack))
		else stop_with_error("Outputs not idle during or right after reset");

	a_wb_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(wb_cyc && wb_stb) |=> wb_ack)
		else stop_with_error("Wishbone ack missing one cycle after the strobe");

	a_wb_ack_once: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else stop_with_error("Wishbone ack held for more than one cycle");

	a_wb_readback: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_ack && rd_chk) |-> (wb_rdat == rd_exp))
		else report_mismatch("wb_readback", $sampled(rd_exp), $sampled(wb_rdat));

	a_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		addr_rdy |-> exp_valid)
		else stop_with_error("Address presented with nothing left to expect");

	// Id order falls out of the in-order queue
	a_addr_value: assert property (@(posedge clk) disable iff (!rst_n)
		(addr_rdy && exp_valid) |-> (addr_out == exp_head))
		else report_mismatch("addr_out", $sampled(exp_head), $sampled(addr_out));

	a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(addr_rdy && !addr_ack) |=> (addr_rdy && $stable(addr_out)))
		else stop_with_error("Address changed or dropped while stalled");

	a_lat_early: assert property (@(posedge clk) disable iff (!rst_n)
		($past(lat_arm, 1) || $past(lat_arm, 2) || $past(lat_arm, 3)) |-> !addr_rdy)
		else stop_with_error("First address came before 3 cycles");

	a_lat_due: assert property (@(posedge clk) disable iff (!rst_n)
		$past(lat_arm, 4) |-> addr_rdy)
		else stop_with_error("First address not ready 3 cycles after the request");

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat   = '0;
		req_rdy  = 1'b0;
		req      = '0;
		rand_ack = 1'b0;
		lat_arm  = 1'b0;
		rd_chk   = 1'b0;
		rd_exp   = '0;
		lfsr     = 16'd58;
		for (int a = 0; a < N_WORDS; a++) begin
			shadow[a] = '0;
		end
		build_stimulus();
		wait (rst_n);

		// Table load and read-back
		for (int a = 0; a < N_WORDS; a++) begin
			wb_access(1'b1, 4'(a), wr_words[a]);
		end
		for (int a = 0; a < N_WORDS; a++) begin
			wb_access(1'b0, 4'(a), 32'h0);
		end

		// First request on an empty pipeline with the sink always ready
		send_req(reqs[0], 1'b1);
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		rand_ack = 1'b1;
		for (int n = 1; n < N_REQ; n++) begin
			send_req(reqs[n], 1'b0);
		end
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		// Idle window to catch stray addresses
		repeat (4) @(posedge clk);
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+design
design/tau_pkg.sv
design/tau_cfg_regs.sv
design/tau_chunk_head.sv
design/tau_linearize.sv
design/tau_top.sv
verification/tb_clkgen.sv
verification/tb_top.sv

// ==== Bender.yml ====
package:
  name: tau_addr_gen

sources:
  - include_dirs:
      - design
    files:
      - design/tau_pkg.sv
      - design/tau_cfg_regs.sv
      - design/tau_chunk_head.sv
      - design/tau_linearize.sv
      - design/tau_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/tb_clkgen.sv
      - verification/tb_top.sv
